// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = armCoreTb
FILELIST = compile.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
logic/armIsaPkg.sv
logic/armPipePkg.sv
logic/armDecoder.sv
logic/condUnit.sv
logic/armAlu.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/armCore.sv
sim/armCoreChecker.sv
sim/armCoreTb.sv

// File: logic/armAlu.sv
// ####################
// 32-bit ALU of the execute stage: add, subtract, and, or, xor.
// Produces NZCV alongside the result; C and V are only
// non-zero for the add and subtract operations.
// ####################
`timescale 1ns/1ps
`default_nettype none

module armAlu import armIsaPkg::*; (
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   input  aluOp                 op,
   output logic [dataWidth-1:0] result,
   output armFlags              flags
);

   logic                 subtract;
   logic                 addSub;
   logic [dataWidth-1:0] bIn;
   logic [dataWidth:0]   sum;

   assign subtract = (op == aluSub);
   assign addSub   = (op == aluAdd) || (op == aluSub);
   assign bIn      = subtract ? ~b : b;                  // Two's complement via carry in
   assign sum      = {1'b0, a} + {1'b0, bIn} + {{dataWidth{1'b0}}, subtract};

   always_comb
   begin
      case (op)
         aluAdd, aluSub: result = sum[dataWidth-1:0];
         aluAnd:         result = a & b;
         aluOrr:         result = a | b;
         aluEor:         result = a ^ b;
         default:        result = '0;
      endcase
   end

   always_comb
   begin
      flags.n = result[dataWidth-1];
      flags.z = (result == '0);
      flags.c = addSub & sum[dataWidth];
      // Operands agree in sign (after inversion) but the sum does not
      flags.v = addSub & ~(a[dataWidth-1] ^ b[dataWidth-1] ^ subtract)
                       & (a[dataWidth-1] ^ sum[dataWidth-1]);
   end

endmodule

`default_nettype wire

// File: logic/armCore.sv
// ####################
// Five-stage pipelined core for the ARMv4 subset.
// Fetch and data memories sit outside: instrF answers pcF and
// readData answers aluOut in the same cycle. Stores commit on the
// rising edge with memWrite high.
// ####################
`timescale 1ns/1ps
`default_nettype none

module armCore import armIsaPkg::*, armPipePkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   output logic [dataWidth-1:0] pcF,
   input  logic [dataWidth-1:0] instrF,
   output logic                 memWrite,
   output logic [dataWidth-1:0] aluOut,
   output logic [dataWidth-1:0] writeData,
   input  logic [dataWidth-1:0] readData
);

   logic [dataWidth-1:0]    pcPlus4F;
   logic [dataWidth-1:0]    pcNextF;
   logic [dataWidth-1:0]    branchTarget;
   logic [dataWidth-1:0]    instrD;
   logic [dataWidth-1:0]    pcPlus4D;
   logic [dataWidth-1:0]    pcPlus8D;
   logic [dataWidth-1:0]    extImmD;
   logic [dataWidth-1:0]    rd1D;
   logic [dataWidth-1:0]    rd2D;
   logic [regAddrWidth-1:0] ra1D;
   logic [regAddrWidth-1:0] ra2D;
   ctrlBundle               ctrlD;
   ctrlBundle               ctrlE;
   exeOperands              exeD;
   exeOperands              exeQ;
   logic [dataWidth-1:0]    srcAE;
   logic [dataWidth-1:0]    srcBE;
   logic [dataWidth-1:0]    writeDataE;
   logic [dataWidth-1:0]    aluResultE;
   armFlags                 aluFlagsE;
   logic                    regWriteG;
   logic                    memWriteG;
   logic                    branchTaken;
   memStage                 memQ;
   wbStage                  wbQ;
   logic [dataWidth-1:0]    resultW;
   fwdSel                   fwdA;
   fwdSel                   fwdB;
   logic                    stallF;
   logic                    stallD;
   logic                    flushD;
   logic                    flushE;

   // Fetch
   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = branchTaken ? branchTarget : pcPlus4F;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)       pcF <= '0;
      else if (!stallF) pcF <= pcNextF;
   end

   // Decode register, flushed behind a taken branch
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         instrD   <= '0;
         pcPlus4D <= '0;
      end
      else if (flushD)
      begin
         instrD   <= '0;
         pcPlus4D <= '0;
      end
      else if (!stallD)
      begin
         instrD   <= instrF;
         pcPlus4D <= pcPlus4F;
      end
   end

   assign pcPlus8D = pcPlus4D + (pcReadOffset - 32'd4); // Instr address + 8

   armDecoder decoder_i (
      .instr  (instrD),
      .ctrl   (ctrlD),
      .extImm (extImmD),
      .ra1    (ra1D),
      .ra2    (ra2D)
   );

   regFile regFile_i (
      .clk     (clk),
      .we      (wbQ.regWrite),
      .ra1     (ra1D),
      .ra2     (ra2D),
      .wa      (wbQ.wa3),
      .wd      (resultW),
      .pcPlus8 (pcPlus8D),
      .rd1     (rd1D),
      .rd2     (rd2D)
   );

   assign exeD = '{rd1: rd1D, rd2: rd2D, extImm: extImmD, ra1: ra1D, ra2: ra2D,
                   wa3: instrD[15:12], pcPlus4: pcPlus4D};

   // Execute register; only the control side needs clearing for a bubble
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctrlE <= '0;
         exeQ  <= '0;
      end
      else
      begin
         ctrlE <= flushE ? '0 : ctrlD;
         exeQ  <= exeD;
      end
   end

   // Operand forwarding
   always_comb
   begin
      case (fwdA)
         fwdMem:  srcAE = memQ.aluOut;
         fwdWb:   srcAE = resultW;
         default: srcAE = exeQ.rd1;
      endcase
      case (fwdB)
         fwdMem:  writeDataE = memQ.aluOut;
         fwdWb:   writeDataE = resultW;
         default: writeDataE = exeQ.rd2;
      endcase
   end

   assign srcBE        = ctrlE.aluSrcImm ? exeQ.extImm : writeDataE;
   assign branchTarget = exeQ.pcPlus4 + (pcReadOffset - 32'd4) + exeQ.extImm;

   armAlu alu_i (
      .a      (srcAE),
      .b      (srcBE),
      .op     (ctrlE.alu),
      .result (aluResultE),
      .flags  (aluFlagsE)
   );

   condUnit cond_i (
      .clk         (clk),
      .reset       (reset),
      .ctrlE       (ctrlE),
      .aluFlags    (aluFlagsE),
      .regWriteG   (regWriteG),
      .memWriteG   (memWriteG),
      .branchTaken (branchTaken)
   );

   // Memory and writeback registers
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         memQ <= '0;
         wbQ  <= '0;
      end
      else
      begin
         memQ <= '{regWrite: regWriteG, memWrite: memWriteG, memToReg: ctrlE.memToReg,
                   aluOut: aluResultE, writeData: writeDataE, wa3: exeQ.wa3};
         wbQ  <= '{regWrite: memQ.regWrite, memToReg: memQ.memToReg, aluOut: memQ.aluOut,
                   readData: readData, wa3: memQ.wa3};
      end
   end

   assign memWrite  = memQ.memWrite;
   assign aluOut    = memQ.aluOut;
   assign writeData = memQ.writeData;
   assign resultW   = wbQ.memToReg ? wbQ.readData : wbQ.aluOut;

   hazardUnit hazard_i (
      .ra1D        (ra1D),
      .ra2D        (ra2D),
      .ra1E        (exeQ.ra1),
      .ra2E        (exeQ.ra2),
      .wa3E        (exeQ.wa3),
      .wa3M        (memQ.wa3),
      .wa3W        (wbQ.wa3),
      .regWriteM   (memQ.regWrite),
      .regWriteW   (wbQ.regWrite),
      .memToRegE   (ctrlE.memToReg),
      .branchTaken (branchTaken),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .stallF      (stallF),
      .stallD      (stallD),
      .flushD      (flushD),
      .flushE      (flushE)
   );

endmodule

`default_nettype wire

// File: logic/armDecoder.sv
// ####################
// Decode stage logic: builds the control bundle, picks the
// register read addresses and extends the immediate field.
// Purely combinational, fed from the decode instruction register.
// ####################
`timescale 1ns/1ps
`default_nettype none

module armDecoder import armIsaPkg::*, armPipePkg::*; (
   input  logic [dataWidth-1:0]    instr,
   output ctrlBundle               ctrl,
   output logic [dataWidth-1:0]    extImm,
   output logic [regAddrWidth-1:0] ra1,
   output logic [regAddrWidth-1:0] ra2
);

   opClass  cls;
   dpOpcode funct;
   immSrc   immKind;

   assign cls   = opClass'(instr[27:26]);
   assign funct = dpOpcode'(instr[24:21]);

   always_comb
   begin
      ctrl      = '0;
      ctrl.cond = condCode'(instr[31:28]);
      ctrl.alu  = aluAdd;                // address and default add
      immKind   = imm8;
      ra1       = instr[19:16];
      ra2       = instr[3:0];
      case (cls)
         dataProc:
         begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = instr[25];
            case (funct)
               opAdd: ctrl.alu = aluAdd;
               opSub: ctrl.alu = aluSub;
               opAnd: ctrl.alu = aluAnd;
               opOrr: ctrl.alu = aluOrr;
               opEor: ctrl.alu = aluEor;
               default: ctrl.regWrite = 1'b0; // Unsupported funct
            endcase
            ctrl.flagWriteNz = instr[20] & ctrl.regWrite;
            // Carry and overflow only meaningful from the adder
            ctrl.flagWriteCv = ctrl.flagWriteNz & (ctrl.alu == aluAdd || ctrl.alu == aluSub);
         end
         memory:
         begin
            immKind        = imm12;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memToReg  = instr[20];     // L bit
            ctrl.regWrite  = instr[20];
            ctrl.memWrite  = ~instr[20];
            if (!instr[20])
            begin
               ra2 = instr[15:12];          // Store data comes from Rd
            end
         end
         branch:
         begin
            immKind     = immBranch;
            ctrl.branch = 1'b1;
            ra1         = pcRegIndex;       // No register operands
            ra2         = pcRegIndex;
         end
         default: ctrl.cond = condEq;
      endcase
   end

   always_comb
   begin
      case (immKind)
         imm12:     extImm = {{(dataWidth-12){1'b0}}, instr[11:0]};
         immBranch: extImm = {{6{instr[23]}}, instr[23:0], 2'b00}; // Word offset
         default:   extImm = {{(dataWidth-8){1'b0}}, instr[7:0]};
      endcase
   end

endmodule

`default_nettype wire

// File: logic/armIsaPkg.sv
// ####################
// Instruction set encodings for the ARMv4 subset core.
// Import with a wildcard in the module header wherever an
// opcode, condition, ALU operation or flag field is decoded.
// ####################
`default_nettype none

package armIsaPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;

   localparam logic [regAddrWidth-1:0] pcRegIndex   = 4'd15;
   localparam logic [dataWidth-1:0]    pcReadOffset = 32'd8; // R15 reads ahead of the instr

   // Instruction class, bits 27:26
   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01,
      branch   = 2'b10
   } opClass;

   // Data-processing funct, bits 24:21
   typedef enum logic [3:0] {
      opAnd = 4'b0000,
      opEor = 4'b0001,
      opSub = 4'b0010,
      opAdd = 4'b0100,
      opOrr = 4'b1100
   } dpOpcode;

   typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluEor} aluOp;

   // Condition field, bits 31:28
   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl
   } condCode;

   typedef enum logic [1:0] {imm8, imm12, immBranch} immSrc;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } armFlags;

endpackage

`default_nettype wire

// File: logic/armPipePkg.sv
// ####################
// Bundles carried between the pipeline stages of the core.
// Decode builds a ctrlBundle; the execute, memory and writeback
// registers hold the structs below. Needs armIsaPkg compiled first.
// ####################
`default_nettype none

package armPipePkg;

   import armIsaPkg::*;

   // Control produced in decode, registered into execute
   typedef struct packed {
      logic    regWrite;
      logic    memWrite;
      logic    memToReg;
      logic    branch;
      logic    aluSrcImm;
      aluOp    alu;
      logic    flagWriteNz;
      logic    flagWriteCv;
      condCode cond;
   } ctrlBundle;

   // Data side of the decode to execute register
   typedef struct packed {
      logic [dataWidth-1:0]    rd1;
      logic [dataWidth-1:0]    rd2;
      logic [dataWidth-1:0]    extImm;
      logic [regAddrWidth-1:0] ra1;
      logic [regAddrWidth-1:0] ra2;
      logic [regAddrWidth-1:0] wa3;
      logic [dataWidth-1:0]    pcPlus4;
   } exeOperands;

   typedef struct packed {
      logic                    regWrite;
      logic                    memWrite;
      logic                    memToReg;
      logic [dataWidth-1:0]    aluOut;
      logic [dataWidth-1:0]    writeData;
      logic [regAddrWidth-1:0] wa3;
   } memStage;

   typedef struct packed {
      logic                    regWrite;
      logic                    memToReg;
      logic [dataWidth-1:0]    aluOut;
      logic [dataWidth-1:0]    readData;
      logic [regAddrWidth-1:0] wa3;
   } wbStage;

   typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwdSel;

endpackage

`default_nettype wire

// File: logic/condUnit.sv
// ####################
// Condition logic for the execute stage. Holds NZCV, checks the
// instruction's condition field and gates register write, memory
// write and branch. Flags update at the end of the execute cycle.
// ####################
`timescale 1ns/1ps
`default_nettype none

module condUnit import armIsaPkg::*, armPipePkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  ctrlBundle ctrlE,
   input  armFlags   aluFlags,
   output logic      regWriteG,
   output logic      memWriteG,
   output logic      branchTaken
);

   armFlags flags;
   logic    condEx;
   logic    ge;

   assign ge = (flags.n == flags.v); // Signed greater or equal

   always_comb
   begin
      case (ctrlE.cond)
         condEq:  condEx = flags.z;
         condNe:  condEx = ~flags.z;
         condCs:  condEx = flags.c;
         condCc:  condEx = ~flags.c;
         condMi:  condEx = flags.n;
         condPl:  condEx = ~flags.n;
         condVs:  condEx = flags.v;
         condVc:  condEx = ~flags.v;
         condHi:  condEx = flags.c & ~flags.z;
         condLs:  condEx = ~flags.c | flags.z;
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags.z & ge;
         condLe:  condEx = flags.z | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;     // 4'b1111 never executes
      endcase
   end

   // NZ and CV written separately
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags <= '0;
      end
      else
      begin
         if (ctrlE.flagWriteNz && condEx)
         begin
            flags.n <= aluFlags.n;
            flags.z <= aluFlags.z;
         end
         if (ctrlE.flagWriteCv && condEx)
         begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

   assign regWriteG   = ctrlE.regWrite & condEx;
   assign memWriteG   = ctrlE.memWrite & condEx;
   assign branchTaken = ctrlE.branch & condEx;

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
// ####################
// Hazard control: operand forwarding selects for execute,
// load-use stall of fetch and decode, and the flushes for
// a stall bubble or a taken branch.
// ####################
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import armIsaPkg::*, armPipePkg::*; (
   input  logic [regAddrWidth-1:0] ra1D,
   input  logic [regAddrWidth-1:0] ra2D,
   input  logic [regAddrWidth-1:0] ra1E,
   input  logic [regAddrWidth-1:0] ra2E,
   input  logic [regAddrWidth-1:0] wa3E,
   input  logic [regAddrWidth-1:0] wa3M,
   input  logic [regAddrWidth-1:0] wa3W,
   input  logic                    regWriteM,
   input  logic                    regWriteW,
   input  logic                    memToRegE,
   input  logic                    branchTaken,
   output fwdSel                   fwdA,
   output fwdSel                   fwdB,
   output logic                    stallF,
   output logic                    stallD,
   output logic                    flushD,
   output logic                    flushE
);

   logic ldrStall;

   // Youngest producer wins
   always_comb
   begin
      if (regWriteM && wa3M == ra1E)      fwdA = fwdMem;
      else if (regWriteW && wa3W == ra1E) fwdA = fwdWb;
      else                                fwdA = fwdNone;

      if (regWriteM && wa3M == ra2E)      fwdB = fwdMem;
      else if (regWriteW && wa3W == ra2E) fwdB = fwdWb;
      else                                fwdB = fwdNone;
   end

   // Load data arrives too late for forwarding from memory
   assign ldrStall = memToRegE && (wa3E == ra1D || wa3E == ra2D);

   assign stallF = ldrStall;
   assign stallD = ldrStall;
   assign flushD = branchTaken;             // Wrong-path fetch
   assign flushE = ldrStall | branchTaken;  // Bubble or wrong-path decode

endmodule

`default_nettype wire

// File: logic/regFile.sv
// ####################
// Register file, R0 to R14, two combinational read ports.
// Writes on the falling edge so decode sees writeback data in
// the same cycle. Index 15 reads back the supplied PC+8.
// ####################
`timescale 1ns/1ps
`default_nettype none

module regFile import armIsaPkg::*; (
   input  logic                    clk,
   input  logic                    we,
   input  logic [regAddrWidth-1:0] ra1,
   input  logic [regAddrWidth-1:0] ra2,
   input  logic [regAddrWidth-1:0] wa,
   input  logic [dataWidth-1:0]    wd,
   input  logic [dataWidth-1:0]    pcPlus8,
   output logic [dataWidth-1:0]    rd1,
   output logic [dataWidth-1:0]    rd2
);

   logic [dataWidth-1:0] regs [pcRegIndex];

   always_ff @(negedge clk)
   begin
      if (we && wa != pcRegIndex)
      begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == pcRegIndex) ? pcPlus8 : regs[ra1];
   assign rd2 = (ra2 == pcRegIndex) ? pcPlus8 : regs[ra2];

endmodule

`default_nettype wire

// File: sim/armCoreChecker.sv
// ####################
// Concurrent assertions on the pipelined core.
// Attached to every armCore instance by the bind below.
// ####################
`timescale 1ns/1ps
`default_nettype none

module armCoreChecker (
   input  logic clk,
   input  logic reset,
   input  logic memWrite,
   input  logic stallF,
   input  logic stallD,
   input  logic flushE,
   input  logic branchTaken
);

   // No store may leave the core while it is held in reset
   noStoreInReset: assert property (@(posedge clk) reset |-> !memWrite)
      else $error("memWrite high during reset");

   stallsTogether: assert property (@(posedge clk) disable iff (reset) stallF == stallD)
      else $error("stallF and stallD differ");

   branchFlushesExe: assert property (@(posedge clk) disable iff (reset) branchTaken |-> flushE)
      else $error("taken branch without flushE");

endmodule

bind armCore armCoreChecker checker_i (
   .clk         (clk),
   .reset       (reset),
   .memWrite    (memWrite),
   .stallF      (stallF),
   .stallD      (stallD),
   .flushE      (flushE),
   .branchTaken (branchTaken)
);

`default_nettype wire

// File: sim/armCoreTb.sv
// ####################
// Directed testbench for the pipelined core. Each test builds a
// small program, runs it on the DUT and on an instruction-level
// model, then compares the stores seen on the data bus.
// ####################
`timescale 1ns/1ps
`default_nettype none

module armCoreTb import armIsaPkg::*;;

   localparam int runCount = 8;      // Program runs, used for the watchdog
   localparam int maxCycles = 200;

   logic                 clk;
   logic                 reset;
   logic [dataWidth-1:0] pcF;
   logic [dataWidth-1:0] instrF;
   logic                 memWrite;
   logic [dataWidth-1:0] aluOut;
   logic [dataWidth-1:0] writeData;
   logic [dataWidth-1:0] readData;

   logic [dataWidth-1:0] rom [64];
   logic [dataWidth-1:0] ram [256];
   logic [dataWidth-1:0] mRam [256];  // Model copy of data memory
   logic [dataWidth-1:0] mRegs [15];
   armFlags              mFlags;
   logic [dataWidth-1:0] prog [$];
   logic [dataWidth-1:0] expAddr [$];
   logic [dataWidth-1:0] expData [$];
   logic [dataWidth-1:0] gotAddr [$];
   logic [dataWidth-1:0] gotData [$];
   logic [31:0]          lfsr = 32'd74712;
   int                   errorCount = 0;
   int                   checkCount = 0;

   armCore dut_i (
      .clk       (clk),
      .reset     (reset),
      .pcF       (pcF),
      .instrF    (instrF),
      .memWrite  (memWrite),
      .aluOut    (aluOut),
      .writeData (writeData),
      .readData  (readData)
   );

   assign instrF   = rom[pcF[7:2]];
   assign readData = ram[aluOut[9:2]];

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Store capture; values read here are the pre-edge ones
   always @(posedge clk)
   begin
      if (!reset && memWrite)
      begin
         ram[aluOut[9:2]] <= writeData;
         gotAddr.push_back(aluOut);
         gotData.push_back(writeData);
      end
   end

   initial
   begin
      #(runCount * maxCycles * 10);
      $display("Watchdog expired before the tests finished");
      $display("Something failed");
      $finish;
   end

   function automatic logic [31:0] randBits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] romFill(int i);
      return {4'hF, 22'd0, i[5:0]};              // Condition NV, never runs
   endfunction

   function automatic logic [31:0] ramFill(int i);
      return {~i[7:0], 8'h3C, i[7:0], i[7:0] ^ 8'hA5};
   endfunction

   function automatic logic [31:0] dp(condCode c, dpOpcode op, logic imm, logic s,
                                      logic [3:0] rd, logic [3:0] rn, logic [7:0] op2);
      return {c, 2'b00, imm, op, s, rn, rd, 4'd0, op2};
   endfunction

   function automatic logic [31:0] mem(condCode c, logic load, logic [3:0] rd,
                                       logic [3:0] rn, logic [11:0] off);
      return {c, 2'b01, 5'b01100, load, rn, rd, off};
   endfunction

   function automatic logic [31:0] br(condCode c, logic [23:0] off);
      return {c, 4'b1010, off};
   endfunction

   function automatic logic condPass(logic [3:0] cc, armFlags f);
      case (cc)
         4'd0:    return f.z;
         4'd1:    return !f.z;
         4'd2:    return f.c;
         4'd3:    return !f.c;
         4'd4:    return f.n;
         4'd5:    return !f.n;
         4'd6:    return f.v;
         4'd7:    return !f.v;
         4'd8:    return f.c && !f.z;
         4'd9:    return !f.c || f.z;
         4'd10:   return f.n == f.v;
         4'd11:   return f.n != f.v;
         4'd12:   return !f.z && f.n == f.v;
         4'd13:   return f.z || f.n != f.v;
         4'd14:   return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] readReg(logic [3:0] r, logic [31:0] pc);
      return (r == 4'd15) ? pc + 32'd8 : mRegs[r];
   endfunction

   // Instruction-level model, one instruction per step
   task automatic modelRun();
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [32:0] full;
      logic        arith;
      logic        ok;
      pc     = '0;
      mFlags = '0;
      while (pc / 4 < prog.size())
      begin
         ins = prog[pc / 4];
         ok  = condPass(ins[31:28], mFlags);
         a   = readReg(ins[19:16], pc);
         b   = ins[25] ? {24'd0, ins[7:0]} : readReg(ins[3:0], pc);
         if (ins[27:26] == 2'b00)
         begin
            arith = 1'b0;
            full  = '0;
            case (ins[24:21])
               4'b0100:
               begin
                  full  = {1'b0, a} + {1'b0, b};
                  arith = 1'b1;
               end
               4'b0010:
               begin
                  full  = {1'b0, a} + {1'b0, ~b} + 33'd1;
                  arith = 1'b1;
                  b     = ~b;                 // Overflow rule sees inverted operand
               end
               4'b0000: full = {1'b0, a & b};
               4'b0001: full = {1'b0, a ^ b};
               default: full = {1'b0, a | b};
            endcase
            res = full[31:0];
            if (ok)
            begin
               mRegs[ins[15:12]] = res;
               if (ins[20])
               begin
                  mFlags.n = res[31];
                  mFlags.z = (res == '0);
                  if (arith)
                  begin
                     mFlags.c = full[32];
                     mFlags.v = (a[31] == b[31]) && (res[31] != a[31]);
                  end
               end
            end
            pc += 4;
         end
         else if (ins[27:26] == 2'b01)
         begin
            res = a + {20'd0, ins[11:0]};
            if (ok && ins[20])
               mRegs[ins[15:12]] = mRam[res[9:2]];
            else if (ok)
            begin
               mRam[res[9:2]] = readReg(ins[15:12], pc);
               expAddr.push_back(res);
               expData.push_back(mRam[res[9:2]]);
            end
            pc += 4;
         end
         else
            pc = ok ? pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00} : pc + 4;
      end
   endtask

   task automatic compareWord(string name, logic [dataWidth-1:0] exp,
                              logic [dataWidth-1:0] act);
      checkCount++;
      if (exp !== act)
      begin
         errorCount++;
         $display("mismatch %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic compareCount(string name, int exp, int act);
      checkCount++;
      if (exp != act)
      begin
         errorCount++;
         $display("mismatch %s store count: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic resetCore();
      @(posedge clk);
      #1 reset = 1'b1;
      repeat (2) @(posedge clk);
      #1 reset = 1'b0;
   endtask

   task automatic runProgram(string name);
      int cycles;
      int n;
      for (int i = 0; i < 64; i++)
         rom[i] = (i < prog.size()) ? prog[i] : romFill(i);
      for (int i = 0; i < 256; i++)
      begin
         ram[i]  = ramFill(i);
         mRam[i] = ramFill(i);
      end
      expAddr.delete();
      expData.delete();
      gotAddr.delete();
      gotData.delete();
      modelRun();
      resetCore();
      cycles = 0;
      while (pcF < 4 * (prog.size() + 4) && cycles < maxCycles)
      begin
         @(posedge clk);
         cycles++;
      end
      #1;
      if (cycles >= maxCycles)
      begin
         errorCount++;
         $display("%s: the core never reached the end of the program", name);
      end
      compareCount(name, expAddr.size(), gotAddr.size());
      n = (expAddr.size() < gotAddr.size()) ? expAddr.size() : gotAddr.size();
      for (int i = 0; i < n; i++)
      begin
         compareWord(name, expAddr[i], gotAddr[i]);
         compareWord(name, expData[i], gotData[i]);
      end
      prog.delete();
   endtask

   task automatic aluOpsTest();
      dpOpcode ops [5];
      logic [7:0] a;
      logic [7:0] b;
      ops = '{opAdd, opSub, opAnd, opOrr, opEor};
      a = 8'(randBits(8));
      b = 8'(randBits(8));
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15)); // R0 = 0
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd1, 4'd0, a));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd2, 4'd0, b));
      for (int k = 0; k < 5; k++)
      begin
         prog.push_back(dp(condAl, ops[k], 1'b1, 1'b0, 4'd3, 4'd1, b));
         prog.push_back(mem(condAl, 1'b0, 4'd3, 4'd0, 12'(8 * k)));
         prog.push_back(dp(condAl, ops[k], 1'b0, 1'b0, 4'd4, 4'd1, 8'd2));
         prog.push_back(mem(condAl, 1'b0, 4'd4, 4'd0, 12'(8 * k + 4)));
      end
      runProgram("aluOps");
   endtask

   task automatic forwardTest();
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd1, 4'd0, 8'(randBits(8))));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd2, 4'd1, 8'(randBits(8))));
      prog.push_back(dp(condAl, opAdd, 1'b0, 1'b0, 4'd3, 4'd1, 8'd2));
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd4, 4'd3, 8'd1));
      prog.push_back(dp(condAl, opEor, 1'b0, 1'b0, 4'd5, 4'd4, 8'd3));
      prog.push_back(mem(condAl, 1'b0, 4'd5, 4'd0, 12'd0));
      prog.push_back(mem(condAl, 1'b0, 4'd4, 4'd0, 12'd4));
      prog.push_back(mem(condAl, 1'b0, 4'd3, 4'd0, 12'd8));
      runProgram("forward");
   endtask

   task automatic loadUseTest();
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd1, 4'd0, 8'(randBits(8))));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd16));
      prog.push_back(mem(condAl, 1'b1, 4'd2, 4'd0, 12'd16));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd3, 4'd2, 8'd1));  // Uses load at once
      prog.push_back(mem(condAl, 1'b0, 4'd3, 4'd0, 12'd20));
      prog.push_back(mem(condAl, 1'b1, 4'd4, 4'd0, 12'd40));
      prog.push_back(dp(condAl, opOrr, 1'b0, 1'b0, 4'd5, 4'd0, 8'd4));
      prog.push_back(mem(condAl, 1'b0, 4'd5, 4'd0, 12'd24));
      prog.push_back(mem(condAl, 1'b1, 4'd6, 4'd0, 12'd44));
      prog.push_back(mem(condAl, 1'b0, 4'd6, 4'd0, 12'd28));
      runProgram("loadUse");
   endtask

   task automatic branchTest();
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd1, 4'd0, 8'(randBits(8))));
      prog.push_back(br(condAl, 24'd1));                                 // Over two stores
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd0));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd4));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd8));
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b1, 4'd2, 4'd1, 8'd1));  // Z set
      prog.push_back(br(condNe, 24'd0));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd12));
      prog.push_back(br(condEq, 24'd0));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd16));
      prog.push_back(mem(condAl, 1'b0, 4'd2, 4'd0, 12'd20));
      runProgram("branch");
   endtask

   task automatic condTest(string name, logic [7:0] a, logic [7:0] b);
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd1, 4'd0, a));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd2, 4'd0, b));
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b1, 4'd3, 4'd1, 8'd2));
      for (int k = 0; k < 15; k++)
         prog.push_back(mem(condCode'(k), 1'b0, 4'd1, 4'd0, 12'(4 * k)));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd5, 4'd0, 8'd0));
      prog.push_back(dp(condGt, opAdd, 1'b1, 1'b0, 4'd5, 4'd5, 8'd1));
      prog.push_back(dp(condLt, opAdd, 1'b1, 1'b0, 4'd5, 4'd5, 8'd2));
      prog.push_back(dp(condCs, opAdd, 1'b1, 1'b0, 4'd5, 4'd5, 8'd4));
      prog.push_back(dp(condEq, opAdd, 1'b1, 1'b0, 4'd5, 4'd5, 8'd8));
      prog.push_back(mem(condAl, 1'b0, 4'd5, 4'd0, 12'd64));
      runProgram(name);
   endtask

   task automatic pcReadTest();
      prog.push_back(dp(condAl, opSub, 1'b0, 1'b0, 4'd0, 4'd15, 8'd15));
      prog.push_back(mem(condAl, 1'b0, 4'd15, 4'd0, 12'd0));           // Stores 4 + 8
      prog.push_back(dp(condAl, opAdd, 1'b0, 1'b0, 4'd1, 4'd0, 8'd15));
      prog.push_back(mem(condAl, 1'b0, 4'd1, 4'd0, 12'd4));
      prog.push_back(dp(condAl, opAdd, 1'b1, 1'b0, 4'd2, 4'd15, 8'd4));
      prog.push_back(mem(condAl, 1'b0, 4'd2, 4'd0, 12'd8));
      runProgram("pcRead");
   endtask

   initial
   begin
      reset = 1'b1;
      for (int i = 0; i < 64; i++)
         rom[i] = romFill(i);
      for (int i = 0; i < 256; i++)
         ram[i] = ramFill(i);
      aluOpsTest();
      forwardTest();
      loadUseTest();
      branchTest();
      condTest("condRandom", 8'(randBits(8)), 8'(randBits(8)));
      condTest("condEqual", 8'd77, 8'd77);
      condTest("condBelow", 8'd3, 8'd200);
      pcReadTest();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire
